// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= memctl.f
TOP       ?= memctl_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)" || exit 1; exit $$status

clean:
	rm -rf $(OBJ_DIR)

// File: logic/memctl_cmd_arbiter.sv
// Command arbiter
`timescale 1ns/10ps
`default_nettype none

module memctl_cmd_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 dbus_cmd_valid_i,
  input  logic                 dbus_cmd_wr_i,
  input  logic [31:0]          dbus_cmd_addr_i,
  input  logic [31:0]          dbus_cmd_data_i,
  input  logic [3:0]           dbus_cmd_mask_i,
  input  logic [2:0]           dbus_cmd_size_i,
  input  logic                 ibus_cmd_valid_i,
  input  logic [31:0]          ibus_cmd_addr_i,
  input  logic [2:0]           ibus_cmd_size_i,
  input  logic                 idle_i,
  output logic                 dbus_cmd_ready_o,
  output logic                 ibus_cmd_ready_o,
  output memctl_pkg::mem_cmd_s cmd_o,
  output logic                 cmd_valid_o
);
  import memctl_pkg::*;

  logic     take_dbus;
  logic     take_ibus;
  mem_cmd_s next_cmd;

  // ready has to drop with no delay, otherwise a second command slips in
  assign dbus_cmd_ready_o = idle_i;
  // I-bus loses a tie so its command stays pending for the next slot
  assign ibus_cmd_ready_o = idle_i & ~dbus_cmd_valid_i;

  assign take_dbus = dbus_cmd_ready_o & dbus_cmd_valid_i;
  assign take_ibus = ibus_cmd_ready_o & ibus_cmd_valid_i;

  always_comb begin
    if (take_dbus) begin
      next_cmd.addr.raw = dbus_cmd_addr_i;
      next_cmd.write    = dbus_cmd_wr_i;
      next_cmd.wdata    = dbus_cmd_data_i;
      next_cmd.mask     = dbus_cmd_mask_i;
      next_cmd.size     = dbus_cmd_size_i;
      next_cmd.purpose  = PURPOSE_DBUS;
    end else begin
      // instruction fetch is always a read
      next_cmd.addr.raw = ibus_cmd_addr_i;
      next_cmd.write    = 1'b0;
      next_cmd.wdata    = '0;
      next_cmd.mask     = 4'hf;
      next_cmd.size     = ibus_cmd_size_i;
      next_cmd.purpose  = PURPOSE_IBUS;
    end
    case (next_cmd.addr.raw[31:28])
      ROM_REGION:                      next_cmd.region = REGION_ROM;
      CSR_REGION:                      next_cmd.region = REGION_CSR;
      SDRAM_REGION_LO, SDRAM_REGION_HI: next_cmd.region = REGION_SDRAM;
      default:                         next_cmd.region = REGION_NONE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= take_dbus | take_ibus;
    end
  end

  // command register holds until the next acceptance
  always_ff @(posedge clk_i) begin
    if (take_dbus | take_ibus) begin
      cmd_o <= next_cmd;
    end
  end

endmodule

`default_nettype wire

// File: logic/memctl_csr_master.sv
// CSR bus master
`timescale 1ns/10ps
`default_nettype none

module memctl_csr_master (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  memctl_pkg::mem_cmd_s cmd_i,
  input  logic                 csr_ack_i,
  input  logic                 csr_stall_i,
  input  logic [31:0]          csr_dat_i,
  output logic                 csr_cyc_o,
  output logic                 csr_stb_o,
  output logic [3:0]           csr_adr_o,
  output logic                 csr_we_o,
  output logic [31:0]          csr_dat_o,
  output logic                 done_o,
  output logic [31:0]          rdata_o
);

  assign done_o = csr_cyc_o & csr_ack_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      csr_cyc_o <= 1'b0;
      csr_stb_o <= 1'b0;
    end else if (start_i) begin
      csr_cyc_o <= 1'b1;
      csr_stb_o <= 1'b1;
    end else if (csr_cyc_o) begin
      // strobe is taken by the slave once stall is low
      if (!csr_stall_i || csr_ack_i) begin
        csr_stb_o <= 1'b0;
      end
      if (csr_ack_i) begin
        csr_cyc_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      csr_adr_o <= cmd_i.addr.raw[5:2];
      csr_we_o  <= cmd_i.write;
      csr_dat_o <= cmd_i.wdata;
    end
    if (done_o) begin
      rdata_o <= csr_dat_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/memctl_pkg.sv
// Memory dispatcher definitions
`default_nettype none

package memctl_pkg;

  // top address nibble of each region
  localparam logic [3:0] ROM_REGION      = 4'h0;
  localparam logic [3:0] CSR_REGION      = 4'h1;
  localparam logic [3:0] SDRAM_REGION_LO = 4'h2;
  localparam logic [3:0] SDRAM_REGION_HI = 4'h3;

  // size codes, anything above SIZE_32 is a burst of 2^(size-2) words
  localparam logic [2:0] SIZE_8  = 3'd0;
  localparam logic [2:0] SIZE_16 = 3'd1;
  localparam logic [2:0] SIZE_32 = 3'd2;

  // longest burst is 2^3 words
  localparam int MAX_BURST_LOG = 3;

  // purpose bit of a command
  localparam logic PURPOSE_IBUS = 1'b0;
  localparam logic PURPOSE_DBUS = 1'b1;

  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_CSR,
    REGION_SDRAM,
    REGION_NONE
  } region_e;

  typedef enum logic [1:0] {
    RSP_ROM,
    RSP_CSR,
    RSP_SDRAM
  } rsp_src_e;

  // SDRAM view of a byte address, 16M halfwords = 32 MB
  typedef struct packed {
    logic [3:0]  top;
    logic [2:0]  spare;
    logic [23:0] hw_index;
    logic        byte_sel;
  } sdram_addr_s;

  typedef union packed {
    logic [31:0] raw;
    sdram_addr_s sdram;
  } cpu_addr_u;

  typedef struct packed {
    cpu_addr_u   addr;
    logic        write;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic [2:0]  size;
    region_e     region;
    logic        purpose;
  } mem_cmd_s;

endpackage

`default_nettype wire

// File: logic/memctl_rsp_mux.sv
// Response router
`timescale 1ns/10ps
`default_nettype none

module memctl_rsp_mux (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 rsp_fire_i,
  input  memctl_pkg::rsp_src_e rsp_src_i,
  input  logic                 rsp_to_dbus_i,
  input  logic [31:0]          rom_data_i,
  input  logic [31:0]          csr_rdata_i,
  input  logic [31:0]          sdram_rdata_i,
  output logic                 dbus_rsp_valid_o,
  output logic [31:0]          dbus_rsp_data_o,
  output logic                 ibus_rsp_valid_o,
  output logic [31:0]          ibus_rsp_data_o
);
  import memctl_pkg::*;

  logic        fire_q;
  rsp_src_e    src_q;
  logic        to_dbus_q;
  logic [31:0] rsp_data;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      fire_q <= 1'b0;
    end else begin
      fire_q <= rsp_fire_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_fire_i) begin
      src_q     <= rsp_src_i;
      to_dbus_q <= rsp_to_dbus_i;
    end
  end

  // ROM data is combinational and lines up with the registered ROM address
  always_comb begin
    case (src_q)
      RSP_CSR:   rsp_data = csr_rdata_i;
      RSP_SDRAM: rsp_data = sdram_rdata_i;
      default:   rsp_data = rom_data_i;
    endcase
  end

  assign dbus_rsp_valid_o = fire_q & to_dbus_q;
  assign ibus_rsp_valid_o = fire_q & ~to_dbus_q;
  assign dbus_rsp_data_o  = rsp_data;
  assign ibus_rsp_data_o  = rsp_data;

endmodule

`default_nettype wire

// File: logic/memctl_sdram_port.sv
// SDRAM halfword port
`timescale 1ns/10ps
`default_nettype none

module memctl_sdram_port (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  memctl_pkg::mem_cmd_s cmd_i,
  input  logic                 sdram_rdy_i,
  input  logic [15:0]          sdram_rdata_i,
  output logic                 sdram_rd_o,
  output logic                 sdram_wr_o,
  output logic [23:0]          sdram_addr_o,
  output logic [15:0]          sdram_wdata_o,
  output logic [1:0]           sdram_wmask_o,
  output logic                 done_o,
  output logic [31:0]          rdata_o
);
  import memctl_pkg::*;

  logic two_half;
  logic last_half;
  logic hi_half;
  logic gap;

  // reads always fetch a full word, only narrow writes use a single halfword
  assign two_half  = ~(cmd_i.write & (cmd_i.size < SIZE_32));
  assign last_half = hi_half | ~two_half;
  assign done_o    = (sdram_rd_o | sdram_wr_o) & sdram_rdy_i & last_half;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sdram_rd_o <= 1'b0;
      sdram_wr_o <= 1'b0;
      hi_half    <= 1'b0;
      gap        <= 1'b0;
    end else if (start_i) begin
      sdram_rd_o <= ~cmd_i.write;
      sdram_wr_o <= cmd_i.write;
      hi_half    <= 1'b0;
      gap        <= 1'b0;
    end else if (gap) begin
      // request levels drop for one cycle between the two halves
      gap        <= 1'b0;
      sdram_rd_o <= ~cmd_i.write;
      sdram_wr_o <= cmd_i.write;
    end else if ((sdram_rd_o | sdram_wr_o) && sdram_rdy_i) begin
      sdram_rd_o <= 1'b0;
      sdram_wr_o <= 1'b0;
      if (!last_half) begin
        hi_half <= 1'b1;
        gap     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      if (two_half) begin
        // low halfword at the even index goes first
        sdram_addr_o <= {cmd_i.addr.sdram.hw_index[23:1], 1'b0};
      end else begin
        sdram_addr_o <= cmd_i.addr.sdram.hw_index;
      end
      // narrow data is repeated across the word, so the low half always fits
      sdram_wdata_o <= cmd_i.wdata[15:0];
      if (cmd_i.size == SIZE_8) begin
        sdram_wmask_o <= cmd_i.mask[1:0] | cmd_i.mask[3:2];
      end else begin
        sdram_wmask_o <= 2'b11;
      end
    end else if (gap) begin
      sdram_addr_o[0] <= 1'b1;
      sdram_wdata_o   <= cmd_i.wdata[31:16];
    end
  end

  // read word assembly
  always_ff @(posedge clk_i) begin
    if (sdram_rd_o && sdram_rdy_i) begin
      if (hi_half) begin
        rdata_o[31:16] <= sdram_rdata_i;
      end else begin
        rdata_o[15:0] <= sdram_rdata_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/memctl_sequencer.sv
// Transaction sequencer
`timescale 1ns/10ps
`default_nettype none

module memctl_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  memctl_pkg::mem_cmd_s cmd_i,
  input  logic                 cmd_valid_i,
  input  logic                 sdram_done_i,
  input  logic                 csr_done_i,
  output logic                 idle_o,
  output logic [31:0]          rom_addr_o,
  output logic                 sdram_start_o,
  output logic                 csr_start_o,
  output logic                 rsp_fire_o,
  output memctl_pkg::rsp_src_e rsp_src_o,
  output logic                 rsp_to_dbus_o
);
  import memctl_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ROM,
    S_CSR,
    S_SDRAM,
    S_FINISH
  } seq_state_e;

  seq_state_e               state;
  logic [MAX_BURST_LOG-1:0] beat_cnt;
  logic [MAX_BURST_LOG-1:0] burst_beats;
  logic                     start;
  logic                     rom_read;

  assign start    = cmd_valid_i & (state == S_IDLE);
  assign rom_read = start & (cmd_i.region == REGION_ROM) & ~cmd_i.write;

  // beats that follow the first one, oversized bursts are clipped
  always_comb begin
    if (cmd_i.size <= SIZE_32) begin
      burst_beats = '0;
    end else if (cmd_i.size - SIZE_32 >= 3'(MAX_BURST_LOG)) begin
      burst_beats = '1;
    end else begin
      burst_beats = MAX_BURST_LOG'((1 << (cmd_i.size - SIZE_32)) - 1);
    end
  end

  // cmd_valid_i already counts as busy, so ready drops right after acceptance
  assign idle_o        = (state == S_IDLE) & ~cmd_valid_i;
  assign csr_start_o   = start & (cmd_i.region == REGION_CSR);
  assign sdram_start_o = start & (cmd_i.region == REGION_SDRAM);

  // first ROM beat fires on the start cycle, the rest from S_ROM
  assign rsp_fire_o = rom_read | (state == S_ROM)
                    | ((state == S_CSR) & csr_done_i & ~cmd_i.write)
                    | ((state == S_SDRAM) & sdram_done_i & ~cmd_i.write);

  always_comb begin
    case (cmd_i.region)
      REGION_CSR:   rsp_src_o = RSP_CSR;
      REGION_SDRAM: rsp_src_o = RSP_SDRAM;
      default:      rsp_src_o = RSP_ROM;
    endcase
  end

  assign rsp_to_dbus_o = (cmd_i.purpose == PURPOSE_DBUS);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state    <= S_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid_i) begin
            case (cmd_i.region)
              REGION_ROM: begin
                // ROM writes are dropped silently
                beat_cnt <= burst_beats;
                if (cmd_i.write || burst_beats == '0) begin
                  state <= S_FINISH;
                end else begin
                  state <= S_ROM;
                end
              end
              REGION_CSR:   state <= S_CSR;
              REGION_SDRAM: state <= S_SDRAM;
              default:      state <= S_FINISH;
            endcase
          end
        end
        S_ROM: begin
          beat_cnt <= beat_cnt - MAX_BURST_LOG'(1);
          if (beat_cnt == MAX_BURST_LOG'(1)) begin
            state <= S_FINISH;
          end
        end
        S_CSR: begin
          if (csr_done_i) begin
            state <= S_FINISH;
          end
        end
        S_SDRAM: begin
          if (sdram_done_i) begin
            state <= S_FINISH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // the ROM address leads the response by one cycle, matching the mux register
  always_ff @(posedge clk_i) begin
    if (rom_read) begin
      rom_addr_o <= cmd_i.addr.raw;
    end else if (state == S_ROM) begin
      rom_addr_o <= rom_addr_o + 32'd4;
    end
  end

endmodule

`default_nettype wire

// File: logic/memctl_top.sv
// Memory transaction dispatcher
`timescale 1ns/10ps
`default_nettype none

module memctl_top (
  input  logic        clk_i,
  input  logic        rst_i,
  // data bus
  input  logic        dbus_cmd_valid_i,
  output logic        dbus_cmd_ready_o,
  input  logic        dbus_cmd_wr_i,
  input  logic [31:0] dbus_cmd_addr_i,
  input  logic [31:0] dbus_cmd_data_i,
  input  logic [3:0]  dbus_cmd_mask_i,
  input  logic [2:0]  dbus_cmd_size_i,
  output logic        dbus_rsp_valid_o,
  output logic [31:0] dbus_rsp_data_o,
  // instruction bus
  input  logic        ibus_cmd_valid_i,
  output logic        ibus_cmd_ready_o,
  input  logic [31:0] ibus_cmd_addr_i,
  input  logic [2:0]  ibus_cmd_size_i,
  output logic        ibus_rsp_valid_o,
  output logic [31:0] ibus_rsp_data_o,
  // CSR bus
  output logic        csr_cyc_o,
  output logic        csr_stb_o,
  output logic [3:0]  csr_adr_o,
  output logic        csr_we_o,
  output logic [31:0] csr_dat_o,
  input  logic        csr_ack_i,
  input  logic        csr_stall_i,
  input  logic [31:0] csr_dat_i,
  // SDRAM, addressed in halfwords
  output logic        sdram_rd_o,
  output logic        sdram_wr_o,
  output logic [23:0] sdram_addr_o,
  output logic [15:0] sdram_wdata_o,
  output logic [1:0]  sdram_wmask_o,
  input  logic        sdram_rdy_i,
  input  logic [15:0] sdram_rdata_i,
  // boot ROM
  output logic [31:0] rom_addr_o,
  input  logic [31:0] rom_data_i
);
  import memctl_pkg::*;

  mem_cmd_s    cmd;
  logic        cmd_valid;
  logic        idle;
  logic        sdram_start;
  logic        sdram_done;
  logic        csr_start;
  logic        csr_done;
  logic        rsp_fire;
  rsp_src_e    rsp_src;
  logic        rsp_to_dbus;
  logic [31:0] csr_rdata;
  logic [31:0] sdram_rdata;

  memctl_cmd_arbiter memctl_cmd_arbiter_inst (
    .*,
    .idle_i      (idle),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid)
  );

  memctl_sequencer memctl_sequencer_inst (
    .*,
    .cmd_i         (cmd),
    .cmd_valid_i   (cmd_valid),
    .sdram_done_i  (sdram_done),
    .csr_done_i    (csr_done),
    .idle_o        (idle),
    .sdram_start_o (sdram_start),
    .csr_start_o   (csr_start),
    .rsp_fire_o    (rsp_fire),
    .rsp_src_o     (rsp_src),
    .rsp_to_dbus_o (rsp_to_dbus)
  );

  memctl_sdram_port memctl_sdram_port_inst (
    .*,
    .start_i (sdram_start),
    .cmd_i   (cmd),
    .done_o  (sdram_done),
    .rdata_o (sdram_rdata)
  );

  memctl_csr_master memctl_csr_master_inst (
    .*,
    .start_i (csr_start),
    .cmd_i   (cmd),
    .done_o  (csr_done),
    .rdata_o (csr_rdata)
  );

  memctl_rsp_mux memctl_rsp_mux_inst (
    .*,
    .rsp_fire_i    (rsp_fire),
    .rsp_src_i     (rsp_src),
    .rsp_to_dbus_i (rsp_to_dbus),
    .csr_rdata_i   (csr_rdata),
    .sdram_rdata_i (sdram_rdata)
  );

endmodule

`default_nettype wire

// File: memctl.f
logic/memctl_pkg.sv
logic/memctl_cmd_arbiter.sv
logic/memctl_sequencer.sv
logic/memctl_sdram_port.sv
logic/memctl_csr_master.sv
logic/memctl_rsp_mux.sv
logic/memctl_top.sv
verification/memctl_tb_assertions.sv
verification/memctl_tb.sv

// File: verification/memctl_tb.sv
// Dispatcher testbench
`timescale 1ns/10ps
`default_nettype none

module memctl_tb;
  import memctl_pkg::*;

  localparam logic [31:0] ROM_KEY = 32'h5a5a_c3c3;
  localparam logic [1:0] BUS_I = 2'd0;
  localparam logic [1:0] BUS_D = 2'd1;
  // both buses request in one cycle with the I-bus address offset by 0x80
  localparam logic [1:0] BUS_BOTH = 2'd2;

  typedef struct packed {
    logic [1:0]  bus;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [2:0]  size;
  } stim_s;

  logic clk_i = 1'b0;
  logic rst_i = 1'b1;
  logic dbus_cmd_valid_i, dbus_cmd_ready_o, dbus_cmd_wr_i, dbus_rsp_valid_o;
  logic [31:0] dbus_cmd_addr_i, dbus_cmd_data_i, dbus_rsp_data_o;
  logic [3:0] dbus_cmd_mask_i;
  logic [2:0] dbus_cmd_size_i, ibus_cmd_size_i;
  logic ibus_cmd_valid_i, ibus_cmd_ready_o, ibus_rsp_valid_o;
  logic [31:0] ibus_cmd_addr_i, ibus_rsp_data_o;
  logic csr_cyc_o, csr_stb_o, csr_we_o;
  logic [3:0] csr_adr_o;
  logic [31:0] csr_dat_o;
  logic csr_ack_i = 1'b0;
  logic csr_stall_i = 1'b0;
  logic [31:0] csr_dat_i = '0;
  logic sdram_rd_o, sdram_wr_o;
  logic [23:0] sdram_addr_o;
  logic [15:0] sdram_wdata_o;
  logic [1:0] sdram_wmask_o;
  logic sdram_rdy_i = 1'b0;
  logic [15:0] sdram_rdata_i = '0;
  logic [31:0] rom_addr_o, rom_data_i;

  stim_s table_q[$];
  logic got_bus[$], exp_bus[$];
  logic [31:0] got_data[$], exp_data[$];
  int got_cyc[$];
  logic [31:0] csr_regs [16];
  logic [31:0] csr_ref [16];
  logic [15:0] sdram_mem [int];
  logic [15:0] hw_ref [int];
  logic [31:0] rng = 32'd38;
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 100;
  logic csr_pending = 1'b0;
  logic [1:0] csr_delay = '0;
  logic sdram_busy = 1'b0;
  logic [1:0] sdram_delay = '0;

  memctl_top memctl_top_inst (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] rom_word(input logic [31:0] a);
    return a ^ ROM_KEY;
  endfunction

  assign rom_data_i = rom_word(rom_addr_o);

  // CSR slave with random stall and ack latency
  always @(posedge clk_i) begin
    csr_ack_i <= 1'b0;
    if (!rst_i) begin
      if (csr_pending) begin
        if (csr_delay == 0) begin
          csr_ack_i <= 1'b1;
          csr_pending <= 1'b0;
          if (csr_we_o) begin
            csr_regs[csr_adr_o] <= csr_dat_o;
          end else begin
            csr_dat_i <= csr_regs[csr_adr_o];
          end
        end else begin
          csr_delay <= csr_delay - 2'd1;
        end
      end else begin
        if (csr_cyc_o && csr_stb_o && !csr_stall_i) begin
          csr_pending <= 1'b1;
          csr_delay <= 2'(xorshift() % 3);
        end
        csr_stall_i <= 1'(xorshift());
      end
    end
  end

  // SDRAM halfword memory that answers after 1 to 4 cycles
  always @(posedge clk_i) begin
    sdram_rdy_i <= 1'b0;
    if (!rst_i) begin
      if (sdram_busy) begin
        if (sdram_delay == 0) begin
          sdram_rdy_i <= 1'b1;
          sdram_busy <= 1'b0;
          if (sdram_wr_o) begin
            sdram_mem[sdram_addr_o] = sdram_mem.exists(sdram_addr_o) ?
                                      sdram_mem[sdram_addr_o] : 16'h0;
            if (sdram_wmask_o[0]) sdram_mem[sdram_addr_o][7:0] = sdram_wdata_o[7:0];
            if (sdram_wmask_o[1]) sdram_mem[sdram_addr_o][15:8] = sdram_wdata_o[15:8];
          end else begin
            sdram_rdata_i <= sdram_mem.exists(sdram_addr_o) ? sdram_mem[sdram_addr_o] : 16'h0;
          end
        end else begin
          sdram_delay <= sdram_delay - 2'd1;
        end
      end else if ((sdram_rd_o || sdram_wr_o) && !sdram_rdy_i) begin
        sdram_busy <= 1'b1;
        sdram_delay <= 2'(xorshift() % 4);
      end
    end
  end

  // response monitor
  always @(negedge clk_i) begin
    if (!rst_i && dbus_rsp_valid_o) begin
      got_bus.push_back(1'b1);
      got_data.push_back(dbus_rsp_data_o);
      got_cyc.push_back(cycles);
    end
    if (!rst_i && ibus_rsp_valid_o) begin
      got_bus.push_back(1'b0);
      got_data.push_back(ibus_rsp_data_o);
      got_cyc.push_back(cycles);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no completion after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic add_entry(input logic [1:0] bus, input logic wr, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask, input logic [2:0] size);
    table_q.push_back('{bus, wr, addr, data, mask, size});
  endtask

  // expected responses and reference state for one request
  task automatic predict(input logic is_d, input logic wr, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] mask,
                         input logic [2:0] size);
    int n;
    int idx;
    logic [1:0] m;
    case (addr[31:28])
      ROM_REGION: begin
        if (!wr) begin
          n = (size <= SIZE_32) ? 1 : (size >= 5 ? 8 : (1 << (size - 2)));
          for (int k = 0; k < n; k++) begin
            exp_bus.push_back(is_d);
            exp_data.push_back(rom_word(addr + 32'(4 * k)));
          end
        end
      end
      CSR_REGION: begin
        if (wr) begin
          csr_ref[addr[5:2]] = data;
        end else begin
          exp_bus.push_back(is_d);
          exp_data.push_back(csr_ref[addr[5:2]]);
        end
      end
      SDRAM_REGION_LO, SDRAM_REGION_HI: begin
        idx = int'({addr[24:2], 1'b0});
        if (wr && size >= SIZE_32) begin
          hw_ref[idx] = data[15:0];
          hw_ref[idx + 1] = data[31:16];
        end else if (wr) begin
          idx = int'(addr[24:1]);
          m = (size == SIZE_8) ? (mask[1:0] | mask[3:2]) : 2'b11;
          if (!hw_ref.exists(idx)) hw_ref[idx] = 16'h0;
          if (m[0]) hw_ref[idx][7:0] = data[7:0];
          if (m[1]) hw_ref[idx][15:8] = data[15:8];
        end else begin
          exp_bus.push_back(is_d);
          exp_data.push_back({hw_ref.exists(idx + 1) ? hw_ref[idx + 1] : 16'h0,
                              hw_ref.exists(idx) ? hw_ref[idx] : 16'h0});
        end
      end
      default: ;
    endcase
  endtask

  task automatic run_entry(input stim_s e);
    int base;
    got_bus.delete();
    got_data.delete();
    got_cyc.delete();
    exp_bus.delete();
    exp_data.delete();
    if (e.bus != BUS_I) predict(1'b1, e.wr, e.addr, e.data, e.mask, e.size);
    if (e.bus != BUS_D) predict(1'b0, 1'b0, e.addr + (e.bus == BUS_BOTH ? 32'h80 : 32'h0),
                                e.data, e.mask, e.size);
    @(posedge clk_i);
    if (e.bus != BUS_I) begin
      dbus_cmd_valid_i <= 1'b1;
      dbus_cmd_wr_i <= e.wr;
      dbus_cmd_addr_i <= e.addr;
      dbus_cmd_data_i <= e.data;
      dbus_cmd_mask_i <= e.mask;
      dbus_cmd_size_i <= e.size;
    end
    if (e.bus != BUS_D) begin
      ibus_cmd_valid_i <= 1'b1;
      ibus_cmd_addr_i <= e.addr + (e.bus == BUS_BOTH ? 32'h80 : 32'h0);
      ibus_cmd_size_i <= e.size;
    end
    if (e.bus != BUS_I) begin
      do @(negedge clk_i); while (!dbus_cmd_ready_o);
      @(posedge clk_i);
      dbus_cmd_valid_i <= 1'b0;
    end
    if (e.bus != BUS_D) begin
      do @(negedge clk_i); while (!ibus_cmd_ready_o);
      @(posedge clk_i);
      ibus_cmd_valid_i <= 1'b0;
    end
    do @(negedge clk_i); while (!dbus_cmd_ready_o);
    @(negedge clk_i);
    check_value("response count", 32'(exp_bus.size()), 32'(got_bus.size()));
    for (int k = 0; k < exp_bus.size() && k < got_bus.size(); k++) begin
      check_value("response bus", 32'(exp_bus[k]), 32'(got_bus[k]));
      check_value("response data", exp_data[k], got_data[k]);
    end
    // ROM beats arrive back to back
    if (e.bus != BUS_BOTH && e.addr[31:28] == ROM_REGION && !e.wr) begin
      for (int k = 1; k < got_cyc.size(); k++) begin
        check_value("beat spacing", 32'd1, 32'(got_cyc[k] - got_cyc[k - 1]));
      end
    end
    // halfword layout inside the SDRAM model
    if (e.wr && e.bus == BUS_D && e.addr[31:29] == 3'b001) begin
      base = (e.size >= SIZE_32) ? int'({e.addr[24:2], 1'b0}) : int'(e.addr[24:1]);
      check_value("sdram halfword", 32'(hw_ref[base]), 32'(sdram_mem[base]));
      if (e.size >= SIZE_32) begin
        check_value("sdram halfword", 32'(hw_ref[base + 1]), 32'(sdram_mem[base + 1]));
      end
    end
  endtask

  initial begin
    dbus_cmd_valid_i = 1'b0;
    dbus_cmd_wr_i = 1'b0;
    dbus_cmd_addr_i = '0;
    dbus_cmd_data_i = '0;
    dbus_cmd_mask_i = '0;
    dbus_cmd_size_i = '0;
    ibus_cmd_valid_i = 1'b0;
    ibus_cmd_addr_i = '0;
    ibus_cmd_size_i = '0;
    for (int k = 0; k < 16; k++) begin
      csr_regs[k] = '0;
      csr_ref[k] = '0;
    end
    add_entry(BUS_I, 1'b0, 32'h0000_0100, 32'h0, 4'hf, 3'd5);
    add_entry(BUS_BOTH, 1'b0, 32'h0000_0040, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b0, 32'h0000_0200, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h1000_0014, 32'hcafe_1234, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b0, 32'h1000_0014, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h1000_0008, 32'hdead_beef, 4'hf, SIZE_32);
    add_entry(BUS_I, 1'b0, 32'h1000_0008, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h2000_0010, 32'h1122_3344, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b0, 32'h2000_0010, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_I, 1'b0, 32'h2000_0010, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h2000_0012, 32'hbeef_beef, 4'b1100, SIZE_16);
    add_entry(BUS_D, 1'b1, 32'h2000_0011, 32'h5a5a_5a5a, 4'b0010, SIZE_8);
    add_entry(BUS_D, 1'b0, 32'h2000_0010, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h3000_0040, 32'h8765_4321, 4'hf, SIZE_32);
    add_entry(BUS_I, 1'b0, 32'h3000_0040, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b1, 32'h0000_0300, 32'h1234_5678, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b0, 32'h5000_0000, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_I, 1'b0, 32'hf000_0000, 32'h0, 4'hf, SIZE_32);
    add_entry(BUS_D, 1'b0, 32'h0000_0304, 32'h0, 4'hf, SIZE_32);
    cycle_limit = 40 * table_q.size() + 100;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/memctl_tb_assertions.sv
// Dispatcher protocol assertions
`timescale 1ns/10ps
`default_nettype none

module memctl_tb_assertions (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic dbus_cmd_valid_i,
  input wire logic dbus_cmd_ready_o,
  input wire logic ibus_cmd_valid_i,
  input wire logic ibus_cmd_ready_o,
  input wire logic dbus_rsp_valid_o,
  input wire logic ibus_rsp_valid_o,
  input wire logic csr_cyc_o,
  input wire logic csr_stb_o,
  input wire logic sdram_rd_o,
  input wire logic sdram_wr_o
);

  // ready drops right after an accepted command
  a_ready_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    ((dbus_cmd_valid_i && dbus_cmd_ready_o) || (ibus_cmd_valid_i && ibus_cmd_ready_o))
    |=> (!dbus_cmd_ready_o && !ibus_cmd_ready_o))
    else $error("ready high in the cycle after acceptance");

  // a response belongs to a transaction still in flight
  a_ready_low_on_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    (dbus_rsp_valid_o || ibus_rsp_valid_o) |-> (!dbus_cmd_ready_o && !ibus_cmd_ready_o))
    else $error("ready high while a response is returned");

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_stb_o |-> csr_cyc_o)
    else $error("CSR strobe outside a bus cycle");

  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(sdram_rd_o && sdram_wr_o))
    else $error("SDRAM read and write requested together");

  a_one_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    !(dbus_rsp_valid_o && ibus_rsp_valid_o))
    else $error("response on both buses at once");

endmodule

bind memctl_top memctl_tb_assertions memctl_tb_assertions_inst (.*);

`default_nettype wire
